/* design/bpf_isa_pkg.sv */
package bpf_isa_pkg;

   // Code memory geometry
   localparam int code_addr_w = 6;
   localparam int code_data_w = 64;
   localparam int code_depth  = 1 << code_addr_w;

   // Instruction fields
   localparam int op_msb = 63;
   localparam int op_lsb = 56;
   localparam int jt_msb = 55;    // Taken offset relative to next pc
   localparam int jt_lsb = 48;
   localparam int jf_msb = 47;    // Not-taken offset
   localparam int jf_lsb = 40;
   localparam int k_msb  = 31;
   localparam int k_lsb  = 0;

   // Classic BPF encodings where one exists
   // Any value not listed here rejects the packet
   typedef enum logic [7:0] {
      op_ld_w    = 8'h20,
      op_ld_h    = 8'h28,
      op_ld_b    = 8'h30,
      op_ld_len  = 8'h80,
      op_add_k   = 8'h04,
      op_and_k   = 8'h54,
      op_jeq_k   = 8'h15,
      op_jgt_k   = 8'h25,
      op_jset_k  = 8'h45,
      op_ret_acc = 8'h06,
      op_ret_rej = 8'h0e
   } bpf_op_t;

endpackage

/* design/pktbuf_pkg.sv */
package pktbuf_pkg;

   // Byte 0 of each word sits in bits 31..24
   localparam int pkt_data_w  = 32;
   localparam int pkt_bytes   = 256;
   localparam int pkt_words   = pkt_bytes / (pkt_data_w / 8);
   localparam int pkt_addr_w  = 6;    // Word address
   localparam int byte_addr_w = 8;
   localparam int inc_w       = 3;    // Up to 4 bytes per write
   localparam int plen_w      = 9;    // Holds a full 256-byte packet

   // CPU read width
   typedef enum logic [1:0] {
      sz_byte,
      sz_half,
      sz_word
   } xfer_sz_t;

   // Which stage owns the buffer
   typedef enum logic [1:0] {
      st_snoop,
      st_filter,
      st_forward
   } slot_state_t;

endpackage

/* design/inst_mem.sv */
`timescale 1ns/100ps

module inst_mem (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                wb_cyc,
   input  logic                                wb_stb,
   input  logic                                wb_we,
   input  logic [bpf_isa_pkg::code_addr_w-1:0] wb_adr,
   input  logic [bpf_isa_pkg::code_data_w-1:0] wb_dat_w,
   output logic                                wb_ack,
   input  logic [bpf_isa_pkg::code_addr_w-1:0] rd_addr,
   input  logic                                rd_en,
   output logic [bpf_isa_pkg::code_data_w-1:0] rd_data
);

   logic [bpf_isa_pkg::code_data_w-1:0] mem [bpf_isa_pkg::code_depth];
   logic                                wb_req;

   // Master holds the request until it sees ack
   assign wb_req = wb_cyc && wb_stb && !wb_ack;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= wb_req;    // Reads are acked too but return nothing
      end
   end

   always_ff @(posedge clk) begin
      if (wb_req && wb_we) begin
         mem[wb_adr] <= wb_dat_w;
      end
      // CPU fetch port
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

/* design/packet_buffer.sv */
`timescale 1ns/100ps

module packet_buffer (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic [pktbuf_pkg::pkt_addr_w-1:0]  sn_addr,
   input  logic [pktbuf_pkg::pkt_data_w-1:0]  sn_wr_data,
   input  logic                               sn_wr_en,
   input  logic [pktbuf_pkg::inc_w-1:0]       sn_byte_inc,
   input  logic                               sn_done,
   output logic                               rdy_for_sn,
   input  logic                               rdy_for_sn_ack,
   input  logic [pktbuf_pkg::byte_addr_w-1:0] byte_rd_addr,
   input  logic                               cpu_rd_en,
   input  pktbuf_pkg::xfer_sz_t               transfer_sz,
   output logic [pktbuf_pkg::pkt_data_w-1:0]  resized_mem_data,
   output logic                               resized_mem_data_vld,
   output logic [pktbuf_pkg::plen_w-1:0]      cpu_byte_len,
   input  logic                               cpu_acc,
   input  logic                               cpu_rej,
   output logic                               rdy_for_cpu,
   input  logic                               rdy_for_cpu_ack,
   input  logic [pktbuf_pkg::pkt_addr_w-1:0]  fwd_addr,
   input  logic                               fwd_rd_en,
   output logic [pktbuf_pkg::pkt_data_w-1:0]  fwd_rd_data,
   output logic                               fwd_rd_data_vld,
   output logic [pktbuf_pkg::plen_w-1:0]      fwd_byte_len,
   input  logic                               fwd_done,
   output logic                               rdy_for_fwd,
   input  logic                               rdy_for_fwd_ack
);

   typedef logic [pktbuf_pkg::plen_w-1:0] plen_t;

   logic [pktbuf_pkg::pkt_data_w-1:0] mem [pktbuf_pkg::pkt_words];
   pktbuf_pkg::slot_state_t           state;
   pktbuf_pkg::slot_state_t           state_after;   // Where the slot goes on done
   logic                              claimed;       // Owner has acked
   logic                              stage_ack;
   logic                              stage_done;
   plen_t                             byte_len;
   logic [pktbuf_pkg::pkt_data_w-1:0] cpu_word;
   logic [pktbuf_pkg::pkt_data_w-1:0] cpu_shifted;
   logic [1:0]                        cpu_off;
   pktbuf_pkg::xfer_sz_t              cpu_sz;

   assign rdy_for_sn   = (state == pktbuf_pkg::st_snoop);
   assign rdy_for_cpu  = (state == pktbuf_pkg::st_filter) && !claimed;
   assign rdy_for_fwd  = (state == pktbuf_pkg::st_forward);
   assign cpu_byte_len = byte_len;
   assign fwd_byte_len = byte_len;

   // Pick the handshake of the current owner
   always_comb begin
      case (state)
         pktbuf_pkg::st_snoop: begin
            stage_ack   = rdy_for_sn_ack;
            stage_done  = sn_done;
            state_after = pktbuf_pkg::st_filter;
         end
         pktbuf_pkg::st_filter: begin
            stage_ack   = rdy_for_cpu_ack;
            stage_done  = cpu_acc || cpu_rej;
            state_after = cpu_acc ? pktbuf_pkg::st_forward : pktbuf_pkg::st_snoop;
         end
         default: begin
            stage_ack   = rdy_for_fwd_ack;
            stage_done  = fwd_done;
            state_after = pktbuf_pkg::st_snoop;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= pktbuf_pkg::st_snoop;
         claimed <= 1'b0;
      end else if (stage_done && (claimed || stage_ack)) begin
         state   <= state_after;
         claimed <= 1'b0;
      end else if (stage_ack) begin
         claimed <= 1'b1;
      end
   end

   // Length restarts with the snooper's first ack
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         byte_len <= '0;
      end else if (rdy_for_sn) begin
         if (rdy_for_sn_ack && !claimed) begin
            byte_len <= sn_wr_en ? plen_t'(sn_byte_inc) : '0;
         end else if (sn_wr_en) begin
            byte_len <= byte_len + plen_t'(sn_byte_inc);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sn_wr_en && rdy_for_sn) begin
         mem[sn_addr] <= sn_wr_data;
      end
      if (cpu_rd_en) begin
         cpu_word <= mem[byte_rd_addr[pktbuf_pkg::byte_addr_w-1:2]];
         cpu_off  <= byte_rd_addr[1:0];
         cpu_sz   <= transfer_sz;
      end
      if (fwd_rd_en) begin
         fwd_rd_data <= mem[fwd_addr];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         resized_mem_data_vld <= 1'b0;
         fwd_rd_data_vld      <= 1'b0;
      end else begin
         resized_mem_data_vld <= cpu_rd_en;
         fwd_rd_data_vld      <= fwd_rd_en;
      end
   end

   // Move the wanted lane up to bit 31 for network order
   assign cpu_shifted = cpu_word << {cpu_off, 3'b000};

   always_comb begin
      case (cpu_sz)
         pktbuf_pkg::sz_byte: resized_mem_data = {24'h0, cpu_shifted[31:24]};
         pktbuf_pkg::sz_half: resized_mem_data = {16'h0, cpu_shifted[31:16]};
         default:             resized_mem_data = cpu_word;
      endcase
   end

endmodule

/* design/bpfcpu.sv */
`timescale 1ns/100ps

module bpfcpu (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                rdy_for_cpu,
   input  logic [pktbuf_pkg::pkt_data_w-1:0]   resized_mem_data,
   input  logic                                resized_mem_data_vld,
   input  logic [pktbuf_pkg::plen_w-1:0]       cpu_byte_len,
   input  logic [bpf_isa_pkg::code_data_w-1:0] inst_rd_data,
   output logic                                rdy_for_cpu_ack,
   output logic [pktbuf_pkg::byte_addr_w-1:0]  byte_rd_addr,
   output logic                                cpu_rd_en,
   output pktbuf_pkg::xfer_sz_t                transfer_sz,
   output logic                                cpu_acc,
   output logic                                cpu_rej,
   output logic [bpf_isa_pkg::code_addr_w-1:0] inst_rd_addr,
   output logic                                inst_rd_en
);

   typedef enum logic [1:0] {
      st_idle,
      st_fetch,
      st_exec,
      st_load_wait
   } cpu_state_t;

   cpu_state_t                          state;
   logic [bpf_isa_pkg::code_addr_w-1:0] pc;
   logic [31:0]                         acc;
   bpf_isa_pkg::bpf_op_t                op;
   logic [7:0]                          jt;
   logic [7:0]                          jf;
   logic [31:0]                         k;
   logic [7:0]                          jmp_off;
   logic [8:0]                          pc_nxt;    // Room for pc plus an 8-bit offset
   logic                                wrapped;
   logic                                is_load;
   logic                                legal;
   logic [31:0]                         ld_off;
   logic [2:0]                          ld_bytes;
   pktbuf_pkg::xfer_sz_t                ld_sz;
   logic                                ld_oob;
   logic                                finish;

   assign op = bpf_isa_pkg::bpf_op_t'(inst_rd_data[bpf_isa_pkg::op_msb:bpf_isa_pkg::op_lsb]);
   assign jt = inst_rd_data[bpf_isa_pkg::jt_msb:bpf_isa_pkg::jt_lsb];
   assign jf = inst_rd_data[bpf_isa_pkg::jf_msb:bpf_isa_pkg::jf_lsb];
   assign k  = inst_rd_data[bpf_isa_pkg::k_msb:bpf_isa_pkg::k_lsb];

   assign inst_rd_addr    = pc;
   assign inst_rd_en      = (state == st_fetch);
   assign rdy_for_cpu_ack = (state == st_idle) && rdy_for_cpu;

   // Decode
   always_comb begin
      is_load  = 1'b0;
      legal    = 1'b1;
      jmp_off  = 8'd0;
      ld_sz    = pktbuf_pkg::sz_word;
      ld_bytes = 3'd4;
      ld_off   = {k[31:2], 2'b00};    // Rounded down to natural alignment
      case (op)
         bpf_isa_pkg::op_ld_b: begin
            is_load  = 1'b1;
            ld_sz    = pktbuf_pkg::sz_byte;
            ld_bytes = 3'd1;
            ld_off   = k;
         end
         bpf_isa_pkg::op_ld_h: begin
            is_load  = 1'b1;
            ld_sz    = pktbuf_pkg::sz_half;
            ld_bytes = 3'd2;
            ld_off   = {k[31:1], 1'b0};
         end
         bpf_isa_pkg::op_ld_w:   is_load = 1'b1;
         bpf_isa_pkg::op_jeq_k:  jmp_off = (acc == k) ? jt : jf;
         bpf_isa_pkg::op_jgt_k:  jmp_off = (acc > k) ? jt : jf;
         bpf_isa_pkg::op_jset_k: jmp_off = (|(acc & k)) ? jt : jf;
         bpf_isa_pkg::op_ld_len, bpf_isa_pkg::op_and_k, bpf_isa_pkg::op_add_k,
         bpf_isa_pkg::op_ret_acc, bpf_isa_pkg::op_ret_rej: ;
         default: legal = 1'b0;
      endcase
   end

   // Falling off the end of code memory rejects
   assign pc_nxt  = 9'(pc) + 9'd1 + 9'(jmp_off);
   assign wrapped = |pc_nxt[8:bpf_isa_pkg::code_addr_w];
   assign ld_oob  = ({1'b0, ld_off} + 33'(ld_bytes)) > 33'(cpu_byte_len);

   assign finish = (op == bpf_isa_pkg::op_ret_acc) || (op == bpf_isa_pkg::op_ret_rej)
                   || !legal || wrapped || (is_load && ld_oob);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= st_idle;
         pc        <= '0;
         acc       <= '0;
         cpu_rd_en <= 1'b0;
         cpu_acc   <= 1'b0;
         cpu_rej   <= 1'b0;
      end else begin
         cpu_rd_en <= 1'b0;
         cpu_acc   <= 1'b0;
         cpu_rej   <= 1'b0;
         case (state)
            st_idle: begin
               if (rdy_for_cpu_ack) begin    // Fresh run for the new packet
                  state <= st_fetch;
                  pc    <= '0;
                  acc   <= '0;
               end
            end
            st_fetch: state <= st_exec;
            st_exec: begin
               pc <= pc_nxt[bpf_isa_pkg::code_addr_w-1:0];
               if (finish) begin
                  state   <= st_idle;
                  cpu_acc <= (op == bpf_isa_pkg::op_ret_acc);
                  cpu_rej <= (op != bpf_isa_pkg::op_ret_acc);
               end else if (is_load) begin
                  state     <= st_load_wait;
                  cpu_rd_en <= 1'b1;
               end else begin
                  state <= st_fetch;
                  case (op)
                     bpf_isa_pkg::op_ld_len: acc <= 32'(cpu_byte_len);
                     bpf_isa_pkg::op_and_k:  acc <= acc & k;
                     bpf_isa_pkg::op_add_k:  acc <= acc + k;
                     default: ;                        // Jumps only move the pc
                  endcase
               end
            end
            default: begin
               // Write-back once the buffer answers
               if (resized_mem_data_vld) begin
                  acc   <= resized_mem_data;
                  state <= st_fetch;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_exec) begin
         byte_rd_addr <= ld_off[pktbuf_pkg::byte_addr_w-1:0];
         transfer_sz  <= ld_sz;
      end
   end

endmodule

/* design/packetfilter_core.sv */
`timescale 1ns/100ps

module packetfilter_core (
   input  logic                                clk,
   input  logic                                rst_n,
   // Code loading
   input  logic                                wb_cyc,
   input  logic                                wb_stb,
   input  logic                                wb_we,
   input  logic [bpf_isa_pkg::code_addr_w-1:0] wb_adr,
   input  logic [bpf_isa_pkg::code_data_w-1:0] wb_dat_w,
   output logic                                wb_ack,
   // Snooper
   input  logic [pktbuf_pkg::pkt_addr_w-1:0]   sn_addr,
   input  logic [pktbuf_pkg::pkt_data_w-1:0]   sn_wr_data,
   input  logic                                sn_wr_en,
   input  logic [pktbuf_pkg::inc_w-1:0]        sn_byte_inc,
   input  logic                                sn_done,
   output logic                                rdy_for_sn,
   input  logic                                rdy_for_sn_ack,
   // Forwarder
   input  logic [pktbuf_pkg::pkt_addr_w-1:0]   fwd_addr,
   input  logic                                fwd_rd_en,
   output logic [pktbuf_pkg::pkt_data_w-1:0]   fwd_rd_data,
   output logic                                fwd_rd_data_vld,
   output logic [pktbuf_pkg::plen_w-1:0]       fwd_byte_len,
   input  logic                                fwd_done,
   output logic                                rdy_for_fwd,
   input  logic                                rdy_for_fwd_ack,
   // Verdict
   output logic                                cpu_acc,
   output logic                                cpu_rej
);

   // Buffer to CPU
   logic [pktbuf_pkg::byte_addr_w-1:0]  byte_rd_addr;
   logic                                cpu_rd_en;
   pktbuf_pkg::xfer_sz_t                transfer_sz;
   logic [pktbuf_pkg::pkt_data_w-1:0]   resized_mem_data;
   logic                                resized_mem_data_vld;
   logic [pktbuf_pkg::plen_w-1:0]       cpu_byte_len;
   logic                                rdy_for_cpu;
   logic                                rdy_for_cpu_ack;

   // Code memory to CPU
   logic [bpf_isa_pkg::code_addr_w-1:0] inst_rd_addr;
   logic                                inst_rd_en;
   logic [bpf_isa_pkg::code_data_w-1:0] inst_rd_data;

   inst_mem u_inst_mem (
      .rd_addr (inst_rd_addr),
      .rd_en   (inst_rd_en),
      .rd_data (inst_rd_data),
      .*
   );

   packet_buffer u_packet_buffer (.*);

   bpfcpu u_bpfcpu (.*);

endmodule

/* testbench/pf_checker.sv */
`timescale 1ns/100ps

module pf_checker (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         wb_cyc,
   input  logic         wb_ack,
   input  logic         rdy_for_sn,
   input  logic         cpu_acc,
   input  logic         cpu_rej,
   input  logic         rdy_for_fwd,
   input  logic [5:0]   fwd_addr,
   input  logic         fwd_rd_en,
   input  logic [31:0]  fwd_rd_data,
   input  logic         fwd_rd_data_vld,
   input  logic [8:0]   fwd_byte_len,
   input  logic         fwd_done,
   input  logic         exp_acc,
   input  logic [8:0]   exp_len,
   input  logic [511:0] exp_pkt,
   input  logic         report,
   input  logic [7:0]   timeouts,
   output logic [15:0]  err_cnt
);

   int   verdict_errs = 0;
   int   data_errs    = 0;
   int   proto_errs   = 0;
   int   words        = 0;    // Words forwarded for the current packet
   int   rd_word      = 0;
   logic pending      = 1'b0; // Accepted packet not yet released
   logic ack_q        = 1'b0;
   logic acc_q        = 1'b0;
   logic rej_q        = 1'b0;

   assign err_cnt = 16'(verdict_errs + data_errs + proto_errs);

   // Sample mid-cycle where DUT outputs have settled
   always @(negedge clk) begin
      if (rst_n) begin
         if (wb_ack && (ack_q || !wb_cyc)) begin
            proto_errs++;
            $display("CHECK FAILED at %0t: wb_ack longer than one cycle or outside a cycle",
                     $time);
         end
         ack_q = wb_ack;
         if (acc_q && (!rdy_for_fwd || fwd_byte_len != exp_len)) begin
            proto_errs++;
            $display("CHECK FAILED at %0t: rdy_for_fwd %0b, length %0d, expected length %0d",
                     $time, rdy_for_fwd, fwd_byte_len, exp_len);
         end
         if (rej_q && (!rdy_for_sn || rdy_for_fwd)) begin
            proto_errs++;
            $display("CHECK FAILED at %0t: buffer not back with the snooper after reject", $time);
         end
         acc_q = cpu_acc;
         rej_q = cpu_rej;
         if (cpu_acc || cpu_rej) begin
            if (cpu_acc == cpu_rej || cpu_acc != exp_acc) begin
               verdict_errs++;
               $display("CHECK FAILED at %0t: verdict acc %0b rej %0b, expected acc %0b",
                        $time, cpu_acc, cpu_rej, exp_acc);
            end
            pending = cpu_acc;
            words   = 0;
         end
         if (pending && rdy_for_sn) begin  // Back-pressure
            proto_errs++;
            $display("CHECK FAILED at %0t: rdy_for_sn high while a packet is held", $time);
         end
         if (rdy_for_fwd && !pending) begin
            proto_errs++;
            $display("CHECK FAILED at %0t: rdy_for_fwd without an accepted packet", $time);
         end
         if (fwd_rd_data_vld) begin
            if (fwd_rd_data !== exp_pkt[511 - 32 * rd_word -: 32]) begin
               data_errs++;
               $display("CHECK FAILED at %0t: word %0d is %h, expected %h", $time, rd_word,
                        fwd_rd_data, exp_pkt[511 - 32 * rd_word -: 32]);
            end
            words++;
         end
         if (fwd_rd_en) rd_word = int'(fwd_addr);  // Data comes back next cycle
         if (fwd_done) begin
            if (words != (int'(exp_len) + 3) / 4) begin
               data_errs++;
               $display("CHECK FAILED at %0t: %0d words forwarded, expected %0d", $time, words,
                        (int'(exp_len) + 3) / 4);
            end
            pending = 1'b0;
         end
      end
   end

   always @(posedge report) begin
      $display("Errors: verdict %0d, data %0d, protocol %0d, timeouts %0d",
               verdict_errs, data_errs, proto_errs, timeouts);
   end

endmodule

/* testbench/tb_packetfilter_core.sv */
`timescale 1ns/100ps

module tb_packetfilter_core;

   logic         clk = 1'b0;
   logic         rst_n;
   logic         wb_cyc;
   logic         wb_stb;
   logic         wb_we;
   logic [5:0]   wb_adr;
   logic [63:0]  wb_dat_w;
   logic         wb_ack;
   logic [5:0]   sn_addr;
   logic [31:0]  sn_wr_data;
   logic         sn_wr_en;
   logic [2:0]   sn_byte_inc;
   logic         sn_done;
   logic         rdy_for_sn;
   logic         rdy_for_sn_ack;
   logic [5:0]   fwd_addr;
   logic         fwd_rd_en;
   logic [31:0]  fwd_rd_data;
   logic         fwd_rd_data_vld;
   logic [8:0]   fwd_byte_len;
   logic         fwd_done;
   logic         rdy_for_fwd;
   logic         rdy_for_fwd_ack;
   logic         cpu_acc;
   logic         cpu_rej;

   logic [63:0]  prog [64];                 // Copy of code memory
   logic [31:0]  lfsr = 32'h10ba_b026;
   logic [511:0] exp_pkt;                   // Byte 0 in the top bits
   logic [8:0]   exp_len;
   logic         exp_acc;
   logic         report = 1'b0;
   logic [7:0]   timeouts = 8'd0;
   logic [15:0]  err_cnt;

   packetfilter_core u_dut (.*);

   pf_checker u_checker (.*);

   always #20 clk = ~clk;

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [63:0] make_inst(input logic [7:0] op, input logic [7:0] jt,
                                             input logic [7:0] jf, input logic [31:0] k);
      return {op, jt, jf, 8'h00, k};
   endfunction

   function automatic logic [63:0] random_inst();
      logic [7:0] jt;
      logic [7:0] jf;
      jt = 8'(take_bits(2));
      jf = 8'(take_bits(2));
      case (take_bits(3) % 7)
         0: return make_inst(bpf_isa_pkg::op_ld_b, 8'd0, 8'd0, take_bits(6));
         1: return make_inst(bpf_isa_pkg::op_ld_w, 8'd0, 8'd0, take_bits(6));
         2: return make_inst(bpf_isa_pkg::op_ld_len, 8'd0, 8'd0, 32'd0);
         3: return make_inst(bpf_isa_pkg::op_and_k, 8'd0, 8'd0, take_bits(32));
         4: return make_inst(bpf_isa_pkg::op_add_k, 8'd0, 8'd0, take_bits(8));
         5: return make_inst(bpf_isa_pkg::op_jgt_k, jt, jf, take_bits(8));
         default: return make_inst(bpf_isa_pkg::op_jset_k, jt, jf, take_bits(8));
      endcase
   endfunction

   // Expected verdict where 1 means accept
   function automatic bit bpf_ref(input logic [63:0] code [64], input logic [511:0] pkt,
                                  input int len);
      int          pc;
      int          nxt;
      logic [31:0] a;
      logic [31:0] k;
      logic [7:0]  jt;
      logic [7:0]  jf;
      longint      off;
      longint      n;
      pc = 0;
      a  = '0;
      for (int step = 0; step < 65; step++) begin
         k   = code[pc][31:0];
         jt  = code[pc][55:48];
         jf  = code[pc][47:40];
         nxt = pc + 1;
         n   = 0;
         off = 0;
         case (code[pc][63:56])
            bpf_isa_pkg::op_ld_b: begin
               n   = 1;
               off = longint'(k);
            end
            bpf_isa_pkg::op_ld_h: begin
               n   = 2;
               off = longint'({k[31:1], 1'b0});
            end
            bpf_isa_pkg::op_ld_w: begin
               n   = 4;
               off = longint'({k[31:2], 2'b00});
            end
            bpf_isa_pkg::op_ld_len: a = 32'(len);
            bpf_isa_pkg::op_and_k:  a = a & k;
            bpf_isa_pkg::op_add_k:  a = a + k;
            bpf_isa_pkg::op_jeq_k:  nxt = nxt + int'((a == k) ? jt : jf);
            bpf_isa_pkg::op_jgt_k:  nxt = nxt + int'((a > k) ? jt : jf);
            bpf_isa_pkg::op_jset_k: nxt = nxt + int'((|(a & k)) ? jt : jf);
            bpf_isa_pkg::op_ret_acc: return 1'b1;
            default: return 1'b0;   // ret_rej and illegal codes
         endcase
         if (n != 0) begin
            if (off + n > longint'(len)) return 1'b0;
            a = '0;
            for (int i = 0; i < int'(n); i++) begin
               a = {a[23:0], pkt[511 - 8 * (int'(off) + i) -: 8]};
            end
         end
         if (nxt >= 64) return 1'b0;  // Ran off the end
         pc = nxt;
      end
      return 1'b0;
   endfunction

   task automatic end_run();
      @(posedge clk);
      report <= 1'b1;
      repeat (2) @(posedge clk);
      if (err_cnt == 16'd0 && timeouts == 8'd0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   endtask

   task automatic give_up(input string what);
      $display("Timeout at %0t: no %s from the DUT", $time, what);
      timeouts = timeouts + 8'd1;
   endtask

   task automatic code_write(input int addr, input logic [63:0] inst);
      int n;
      if (timeouts != 8'd0) return;
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= 1'b1;
      wb_adr   <= 6'(addr);
      wb_dat_w <= inst;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!wb_ack && n < 16);
      if (!wb_ack) begin
         give_up("wb_ack");
         return;
      end
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      prog[addr] = inst;
   endtask

   task automatic snoop(input int len);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!rdy_for_sn && n < 64);
      if (!rdy_for_sn) begin
         give_up("rdy_for_sn");
         return;
      end
      rdy_for_sn_ack <= 1'b1;
      for (int w = 0; w < (len + 3) / 4; w++) begin
         @(posedge clk);
         rdy_for_sn_ack <= 1'b0;
         sn_wr_en       <= 1'b1;
         sn_addr        <= 6'(w);
         sn_wr_data     <= exp_pkt[511 - 32 * w -: 32];
         sn_byte_inc    <= 3'((len - 4 * w > 4) ? 4 : len - 4 * w);  // Short last word
      end
      @(posedge clk);
      sn_wr_en <= 1'b0;
      sn_done  <= 1'b1;
      @(posedge clk);
      sn_done <= 1'b0;
   endtask

   // Random delays hold the slot and stall the snooper
   task automatic forward(input int len);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!rdy_for_fwd && n < 16);
      if (!rdy_for_fwd) begin
         give_up("rdy_for_fwd");
         return;
      end
      repeat (int'(take_bits(4))) @(posedge clk);
      rdy_for_fwd_ack <= 1'b1;
      for (int w = 0; w < (len + 3) / 4; w++) begin
         @(posedge clk);
         rdy_for_fwd_ack <= 1'b0;
         fwd_rd_en       <= 1'b1;
         fwd_addr        <= 6'(w);
      end
      @(posedge clk);
      fwd_rd_en <= 1'b0;
      repeat (int'(take_bits(4))) @(posedge clk);
      fwd_done <= 1'b1;
      @(posedge clk);
      fwd_done <= 1'b0;
   endtask

   task automatic run_packet(input bit steer);
      int len;
      int n;
      if (timeouts != 8'd0) return;
      len = 1 + int'(take_bits(6));
      for (int i = 0; i < 64; i++) begin
         exp_pkt[511 - 8 * i -: 8] = 8'(take_bits(8));
      end
      if (steer && take_bits(1) == 32'd1) exp_pkt[415 -: 16] = 16'h0800;  // Bytes 12 and 13
      exp_acc = bpf_ref(prog, exp_pkt, len);
      exp_len = 9'(len);
      snoop(len);
      if (timeouts != 8'd0) return;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!cpu_acc && !cpu_rej && n < 1000);
      if (!cpu_acc && !cpu_rej) begin
         give_up("verdict");
      end else if (cpu_acc) begin
         forward(len);
      end
   endtask

   initial begin
      rst_n           <= 1'b0;
      wb_cyc          <= 1'b0;
      wb_stb          <= 1'b0;
      wb_we           <= 1'b0;
      wb_adr          <= '0;
      wb_dat_w        <= '0;
      sn_addr         <= '0;
      sn_wr_data      <= '0;
      sn_wr_en        <= 1'b0;
      sn_byte_inc     <= '0;
      sn_done         <= 1'b0;
      rdy_for_sn_ack  <= 1'b0;
      fwd_addr        <= '0;
      fwd_rd_en       <= 1'b0;
      fwd_done        <= 1'b0;
      rdy_for_fwd_ack <= 1'b0;
      exp_pkt = '0;
      exp_len = '0;
      exp_acc = 1'b0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      for (int a = 0; a < 64; a++) begin
         code_write(a, make_inst(bpf_isa_pkg::op_ret_rej, 8'd0, 8'd0, 32'(a * 3 + 1)));
      end

      // Match 16'h0800 at byte 12
      code_write(0, make_inst(bpf_isa_pkg::op_ld_h, 8'd0, 8'd0, 32'd12));
      code_write(1, make_inst(bpf_isa_pkg::op_jeq_k, 8'd0, 8'd1, 32'h0800));
      code_write(2, make_inst(bpf_isa_pkg::op_ret_acc, 8'd0, 8'd0, 32'd0));
      code_write(3, make_inst(bpf_isa_pkg::op_ret_rej, 8'd0, 8'd0, 32'd0));
      repeat (40) run_packet(1'b1);

      code_write(0, make_inst(bpf_isa_pkg::op_ld_b, 8'd0, 8'd0, 32'd200));  // Past any packet
      code_write(1, make_inst(bpf_isa_pkg::op_ret_acc, 8'd0, 8'd0, 32'd0));
      repeat (4) run_packet(1'b0);
      code_write(0, make_inst(8'hff, 8'd0, 8'd0, 32'd0));
      repeat (4) run_packet(1'b0);

      // Jump to 62 and step off the end of code memory
      code_write(0, make_inst(bpf_isa_pkg::op_ld_len, 8'd0, 8'd0, 32'd0));
      code_write(1, make_inst(bpf_isa_pkg::op_jgt_k, 8'd60, 8'd60, 32'd0));
      code_write(62, make_inst(bpf_isa_pkg::op_add_k, 8'd0, 8'd0, 32'd1));
      code_write(63, make_inst(bpf_isa_pkg::op_add_k, 8'd0, 8'd0, 32'd1));
      repeat (4) run_packet(1'b0);

      repeat (20) begin
         for (int i = 0; i < 8; i++) begin
            code_write(i, random_inst());
         end
         code_write(8, make_inst(bpf_isa_pkg::op_ret_acc, 8'd0, 8'd0, 32'd0));
         code_write(9, make_inst(bpf_isa_pkg::op_ret_rej, 8'd0, 8'd0, 32'd0));
         repeat (10) run_packet(1'b0);
      end
      end_run();
   end

endmodule

/* vlog.f */
design/bpf_isa_pkg.sv
design/pktbuf_pkg.sv
design/inst_mem.sv
design/packet_buffer.sv
design/bpfcpu.sv
design/packetfilter_core.sv
testbench/pf_checker.sv
testbench/tb_packetfilter_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f vlog.f --top-module tb_packetfilter_core --Mdir obj_dir

out=$(./obj_dir/Vtb_packetfilter_core)
echo "$out"

# Non-zero exit when the pass line is missing
echo "$out" | grep -q "Regression passed"
